// File: list.f
verilog/gfx_pkg.sv
verilog/gfx_cmd_fifo.sv
verilog/gfx_wbs.sv
verilog/gfx_rect_raster.sv
verilog/gfx_top.sv
sim/gfx_raster_assert.sv
sim/gfx_tb.sv

// File: sim/gfx_raster_assert.sv
// fill stage handshake checks, bound into every gfx_rect_raster; needs cmd_i stable during a fill
`timescale 1ns/10ps
module gfx_raster_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 start_i,
  input logic                 done_o,
  input logic                 mem_valid_o,
  input logic                 mem_ready_i,
  input gfx_pkg::gfx_mem_wr_t mem_wr_o
);

  // failures seen so far, read by the testbench
  int   fail_count = 0;
  // set by start, cleared by done
  logic fill_open_q;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      fill_open_q <= 1'b0;
    else if (start_i)
      fill_open_q <= 1'b1;
    else if (done_o)
      fill_open_q <= 1'b0;
  end

  // stalled write holds address and data
  hold_p: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_wr_o))
  else
  begin
    fail_count++;
    $error("memory write changed or dropped while ready was low");
  end

  // done right after the last accepted pixel, or two cycles after start when empty
  done_p: assert property (@(posedge clk_i) disable iff (rst_i)
    done_o |-> !mem_valid_o && ($past(mem_valid_o && mem_ready_i) || $past(start_i, 2)))
  else
  begin
    fail_count++;
    $error("done without a just accepted last pixel or an empty-area start");
  end

  // no second start before done
  start_p: assert property (@(posedge clk_i) disable iff (rst_i) start_i |-> !fill_open_q)
  else
  begin
    fail_count++;
    $error("start arrived while a fill was still running");
  end

endmodule

bind gfx_rect_raster gfx_raster_assert gfx_raster_assert_inst (.*);

// File: sim/gfx_tb.sv
// testbench for gfx_top; fixed LFSR seed, memory model only accepts writes, idle seen via queue wires
`timescale 1ns/10ps
module gfx_tb;
  import gfx_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_LIMIT   = 2000;
  // watchdog budget, 4 cycles per access, 8 per pixel under back-pressure
  localparam int BUS_ACCESSES = 100;
  localparam int FILL_PIXELS  = 280;
  localparam int RUN_CYCLES   = RESET_CYCLES + BUS_ACCESSES * 4 + FILL_PIXELS * 8 + 1000;
  localparam logic [31:0] CTRL_RECT  = 32'h1 << GFX_CTRL_RECT_BIT;
  localparam logic [31:0] CTRL_INTEN = 32'h1 << GFX_CTRL_INTEN_BIT;

  logic        clk_i;
  logic        rst_i;
  logic [9:0]  adr_i;
  logic [31:0] dat_i;
  logic [31:0] dat_o;
  logic [3:0]  sel_i;
  logic        we_i;
  logic        stb_i;
  logic        cyc_i;
  logic        ack_o;
  logic        err_o;
  logic        inta_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  gfx_mem_wr_t mem_wr_o;

  logic [31:0] lfsr_q;
  // accepted pixels and the expected sequence
  logic [29:0] seen_adr[$];
  logic [31:0] seen_data[$];
  logic [29:0] exp_adr[$];
  logic [31:0] exp_data[$];
  int          error_count;
  int          errors_at_start;
  int          test_num;
  int          tests_ok;
  int          tests_bad;
  string       test_name;

  gfx_top gfx_top_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // memory model, one LFSR bit per cycle for ready
  always @(posedge clk_i)
  begin
    if (mem_valid_o && mem_ready_i)
    begin
      seen_adr.push_back(mem_wr_o.adr);
      seen_data.push_back(mem_wr_o.data);
    end
    lfsr_q = lfsr_next(lfsr_q);
    mem_ready_i <= lfsr_q[0];
  end

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD);
    $display("simulation timed out after %0d cycles", RUN_CYCLES);
    $display("Test failed");
    $finish;
  end

  function automatic int total_errors();
    return error_count + gfx_top_inst.gfx_rect_raster_inst.gfx_raster_assert_inst.fail_count;
  endfunction

  function automatic gfx_point_t make_point(input int x, input int y);
    gfx_point_t p;
    p.x = 16'(x);
    p.y = 16'(y);
    return p;
  endfunction

  function automatic gfx_rect_cmd_t make_rect(input int base, input gfx_point_t size,
                                              input gfx_point_t dp0, input gfx_point_t dp1,
                                              input gfx_point_t cp0, input gfx_point_t cp1,
                                              input logic [31:0] color);
    gfx_rect_cmd_t r;
    r.target_base = 30'(base);
    r.target_size = size;
    r.dest_p0     = dp0;
    r.dest_p1     = dp1;
    r.clip_p0     = cp0;
    r.clip_p1     = cp1;
    r.color       = color;
    return r;
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  // one classic cycle, ends on ack or err
  task automatic bus_access(input logic wr, input logic [5:0] idx, input logic [31:0] wdata,
                            input logic [3:0] sel, output logic [31:0] rdata,
                            output logic acked, output logic erred);
    @(posedge clk_i);
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    we_i  <= wr;
    sel_i <= sel;
    adr_i <= {2'b00, idx, 2'b00};
    dat_i <= wdata;
    do
      @(posedge clk_i);
    while (!ack_o && !err_o);
    acked = ack_o;
    erred = err_o;
    rdata = dat_o;
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic reg_write(input logic [5:0] idx, input logic [31:0] data);
    logic [31:0] rd;
    logic        acked;
    logic        erred;
    bus_access(1'b1, idx, data, 4'hf, rd, acked, erred);
    assert (acked && !erred)
    else
    begin
      $display("%0t: write to register %0d was not acknowledged", $time, idx);
      error_count++;
    end
  endtask

  task automatic reg_read(input logic [5:0] idx, output logic [31:0] data);
    logic acked;
    logic erred;
    bus_access(1'b0, idx, '0, 4'hf, data, acked, erred);
    assert (acked && !erred)
    else
    begin
      $display("%0t: read of register %0d was not acknowledged", $time, idx);
      error_count++;
    end
  endtask

  // idle means queue empty, no launch pending and not busy
  task automatic wait_idle();
    int n;
    n = 0;
    do
    begin
      @(posedge clk_i);
      n++;
    end
    while ((gfx_top_inst.pop_valid || !gfx_top_inst.pop_ready) && n < IDLE_LIMIT);
    assert (n < IDLE_LIMIT)
    else
    begin
      $display("%0t: DUT stayed busy for %0d cycles", $time, IDLE_LIMIT);
      error_count++;
    end
  endtask

  // clipped area is the intersection of dest, clip and the target, row major
  task automatic add_expected(input gfx_rect_cmd_t c);
    int xl;
    int xh;
    int yl;
    int yh;
    int x;
    int y;
    xl = (c.dest_p0.x > c.clip_p0.x) ? c.dest_p0.x : c.clip_p0.x;
    yl = (c.dest_p0.y > c.clip_p0.y) ? c.dest_p0.y : c.clip_p0.y;
    xh = c.dest_p1.x;
    if (c.clip_p1.x < xh)
      xh = c.clip_p1.x;
    if (c.target_size.x < xh)
      xh = c.target_size.x;
    yh = c.dest_p1.y;
    if (c.clip_p1.y < yh)
      yh = c.clip_p1.y;
    if (c.target_size.y < yh)
      yh = c.target_size.y;
    for (y = yl; y < yh; y++)
      for (x = xl; x < xh; x++)
      begin
        exp_adr.push_back(c.target_base + 30'(y * c.target_size.x + x));
        exp_data.push_back(c.color);
      end
  endtask

  task automatic compare_writes(input string what);
    int n;
    int i;
    assert (seen_adr.size() == exp_adr.size())
    else
    begin
      $display("FAIL %0t: %s, %0d pixel writes, expected %0d", $time, what,
               seen_adr.size(), exp_adr.size());
      error_count++;
    end
    n = (seen_adr.size() < exp_adr.size()) ? seen_adr.size() : exp_adr.size();
    for (i = 0; i < n; i++)
    begin
      check_word({what, " address"}, {2'b00, seen_adr[i]}, {2'b00, exp_adr[i]});
      check_word({what, " data"}, seen_data[i], exp_data[i]);
    end
    seen_adr.delete();
    seen_data.delete();
    exp_adr.delete();
    exp_data.delete();
  endtask

  task automatic load_rect(input gfx_rect_cmd_t c);
    reg_write(GFX_DEST_P0_ADR, c.dest_p0);
    reg_write(GFX_DEST_P1_ADR, c.dest_p1);
    reg_write(GFX_CLIP_P0_ADR, c.clip_p0);
    reg_write(GFX_CLIP_P1_ADR, c.clip_p1);
    reg_write(GFX_COLOR_ADR, c.color);
    reg_write(GFX_TARGET_BASE_ADR, {2'b00, c.target_base});
    reg_write(GFX_TARGET_SIZE_ADR, c.target_size);
  endtask

  task automatic run_fill(input gfx_rect_cmd_t c, input logic [31:0] ctrl, input string what);
    load_rect(c);
    add_expected(c);
    reg_write(GFX_CONTROL_ADR, ctrl | CTRL_RECT);
    wait_idle();
    compare_writes(what);
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name       = name;
    errors_at_start = total_errors();
  endtask

  task automatic finish_test();
    if (total_errors() == errors_at_start)
    begin
      $display("test %0d %s: ok", test_num, test_name);
      tests_ok++;
    end
    else
    begin
      $display("test %0d %s: %0d errors", test_num, test_name, total_errors() - errors_at_start);
      tests_bad++;
    end
  endtask

  task automatic test_reset_state();
    int          idx_list[9] = '{0, 1, 4, 5, 6, 7, 8, 9, 10};
    logic [31:0] rd;
    start_test("reset state");
    check_word("inta after reset", {31'd0, inta_o}, 32'd0);
    foreach (idx_list[i])
    begin
      reg_read(6'(idx_list[i]), rd);
      check_word($sformatf("register %0d after reset", idx_list[i]), rd, 32'd0);
    end
    finish_test();
  endtask

  task automatic test_register_access();
    logic [31:0] rd;
    logic        acked;
    logic        erred;
    start_test("register access");
    reg_write(GFX_COLOR_ADR, 32'h12345678);
    wait_idle();
    reg_read(GFX_COLOR_ADR, rd);
    check_word("color readback", rd, 32'h12345678);
    // half-word select must be refused
    bus_access(1'b1, GFX_COLOR_ADR, 32'hdeadbeef, 4'b0011, rd, acked, erred);
    check_word("partial write ack/err", {30'd0, acked, erred}, 32'd1);
    wait_idle();
    reg_read(GFX_COLOR_ADR, rd);
    check_word("color after partial write", rd, 32'h12345678);
    finish_test();
  endtask

  task automatic test_fill();
    gfx_rect_cmd_t c;
    logic [31:0]   rd;
    start_test("fill under back-pressure");
    c = make_rect(32'h1000, make_point(20, 10), make_point(2, 3), make_point(7, 6),
                  make_point(0, 0), make_point(20, 10), 32'ha5a50001);
    run_fill(c, 32'd0, "plain fill");
    // not busy any more, done flag now set
    reg_read(GFX_STATUS_ADR, rd);
    check_word("status after fill", rd & 32'h3, 32'h1 << GFX_STAT_DONE_BIT);
    finish_test();
  endtask

  task automatic test_clipping();
    gfx_rect_cmd_t c;
    logic [31:0]   rd;
    start_test("clipping");
    c = make_rect(32'h2000, make_point(16, 8), make_point(1, 1), make_point(25, 5),
                  make_point(4, 2), make_point(18, 12), 32'h0000beef);
    run_fill(c, 32'd0, "partial clip");
    // disjoint dest, no pixels but still done
    reg_write(GFX_STATUS_ADR, 32'd0);
    c.dest_p0 = make_point(30, 20);
    c.dest_p1 = make_point(40, 30);
    run_fill(c, 32'd0, "disjoint fill");
    reg_read(GFX_STATUS_ADR, rd);
    check_word("status after empty fill", rd & 32'h3, 32'h1 << GFX_STAT_DONE_BIT);
    finish_test();
  endtask

  task automatic test_queued();
    gfx_rect_cmd_t a;
    gfx_rect_cmd_t b;
    logic [31:0]   rd;
    start_test("queued commands");
    a = make_rect(32'h400, make_point(32, 16), make_point(0, 0), make_point(20, 10),
                  make_point(0, 0), make_point(32, 16), 32'h00ff00ff);
    b         = a;
    b.dest_p0 = make_point(3, 4);
    b.dest_p1 = make_point(7, 7);
    load_rect(a);
    add_expected(a);
    add_expected(b);
    reg_write(GFX_CONTROL_ADR, CTRL_RECT);
    reg_read(GFX_STATUS_ADR, rd);
    check_word("busy in first fill", {31'd0, rd[GFX_STAT_BUSY_BIT]}, 32'd1);
    // posted while busy, second launch included
    reg_write(GFX_DEST_P0_ADR, b.dest_p0);
    reg_write(GFX_DEST_P1_ADR, b.dest_p1);
    reg_write(GFX_CONTROL_ADR, CTRL_RECT);
    reg_read(GFX_DEST_P0_ADR, rd);
    check_word("dest p0 during fill", rd, a.dest_p0);
    reg_read(GFX_DEST_P1_ADR, rd);
    check_word("dest p1 during fill", rd, a.dest_p1);
    reg_read(GFX_STATUS_ADR, rd);
    check_word("still busy after reads", {31'd0, rd[GFX_STAT_BUSY_BIT]}, 32'd1);
    wait_idle();
    compare_writes("two queued fills");
    reg_read(GFX_DEST_P0_ADR, rd);
    check_word("dest p0 after queue drained", rd, b.dest_p0);
    finish_test();
  endtask

  task automatic test_interrupt();
    gfx_rect_cmd_t c;
    logic [31:0]   rd;
    start_test("interrupt");
    reg_write(GFX_STATUS_ADR, 32'd0);
    reg_write(GFX_CONTROL_ADR, CTRL_INTEN);
    wait_idle();
    check_word("inta before fill", {31'd0, inta_o}, 32'd0);
    c = make_rect(32'h3000, make_point(8, 8), make_point(2, 2), make_point(6, 6),
                  make_point(0, 0), make_point(8, 8), 32'h5a5a5a5a);
    run_fill(c, CTRL_INTEN, "fill with interrupt");
    check_word("inta after fill", {31'd0, inta_o}, 32'd1);
    // rect bit gone, enable stays
    reg_read(GFX_CONTROL_ADR, rd);
    check_word("control after launch", rd, CTRL_INTEN);
    reg_write(GFX_STATUS_ADR, 32'd0);
    wait_idle();
    check_word("inta after status write", {31'd0, inta_o}, 32'd0);
    finish_test();
  endtask

  initial
  begin
    rst_i       = 1'b1;
    adr_i       = '0;
    dat_i       = '0;
    sel_i       = '0;
    we_i        = 1'b0;
    stb_i       = 1'b0;
    cyc_i       = 1'b0;
    mem_ready_i = 1'b0;
    lfsr_q      = 32'd98843;
    error_count = 0;
    test_num    = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset_state();
    test_register_access();
    test_fill();
    test_clipping();
    test_queued();
    test_interrupt();
    $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
             tests_ok, tests_bad, total_errors());
    if (total_errors() == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: verilog/gfx_cmd_fifo.sv
// register write queue; pop data is valid the cycle after a push into an empty queue, no bypass
`timescale 1ns/10ps
module gfx_cmd_fifo (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              push_valid_i,
  output logic              push_ready_o,
  input  gfx_pkg::gfx_cmd_t push_data_i,
  output logic              pop_valid_o,
  input  logic              pop_ready_i,
  output gfx_pkg::gfx_cmd_t pop_data_o
);
  import gfx_pkg::*;

  // storage, no reset needed
  gfx_cmd_t mem_q [GFX_FIFO_DEPTH];

  logic [GFX_FIFO_AW-1:0] wr_ptr_q;
  logic [GFX_FIFO_AW-1:0] rd_ptr_q;
  // one extra bit so that full is distinct from empty
  logic [GFX_FIFO_AW:0]   count_q;
  logic                   push_fire;
  logic                   pop_fire;

  assign push_ready_o = (count_q != GFX_FIFO_DEPTH[GFX_FIFO_AW:0]);
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (push_fire)
      mem_q[wr_ptr_q] <= push_data_i;
  end

  // pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_fire)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_fire)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // simultaneous push and pop leaves the count alone
      if (push_fire && !pop_fire)
        count_q <= count_q + 1'b1;
      else if (pop_fire && !push_fire)
        count_q <= count_q - 1'b1;
    end
  end

endmodule

// File: verilog/gfx_pkg.sv
// shared definitions; 32 bpp only, register index is adr_i[7:2], corners inclusive at p0 and exclusive at p1
package gfx_pkg;

  // register index width, word addressed
  localparam int GFX_REG_AW = 6;

  // register map
  localparam logic [GFX_REG_AW-1:0] GFX_CONTROL_ADR     = 6'd0;
  localparam logic [GFX_REG_AW-1:0] GFX_STATUS_ADR      = 6'd1;
  localparam logic [GFX_REG_AW-1:0] GFX_DEST_P0_ADR     = 6'd4;
  localparam logic [GFX_REG_AW-1:0] GFX_DEST_P1_ADR     = 6'd5;
  localparam logic [GFX_REG_AW-1:0] GFX_CLIP_P0_ADR     = 6'd6;
  localparam logic [GFX_REG_AW-1:0] GFX_CLIP_P1_ADR     = 6'd7;
  localparam logic [GFX_REG_AW-1:0] GFX_COLOR_ADR       = 6'd8;
  localparam logic [GFX_REG_AW-1:0] GFX_TARGET_BASE_ADR = 6'd9;
  localparam logic [GFX_REG_AW-1:0] GFX_TARGET_SIZE_ADR = 6'd10;

  // control register bits
  // rect bit self-clears once the fill is launched
  localparam int GFX_CTRL_INTEN_BIT = 1;
  localparam int GFX_CTRL_RECT_BIT  = 8;

  // status register bits
  localparam int GFX_STAT_BUSY_BIT = 0;
  localparam int GFX_STAT_DONE_BIT = 1;

  // instruction queue
  localparam int GFX_FIFO_DEPTH = 16;
  localparam int GFX_FIFO_AW    = 4;

  // screen point, x in the upper half of a register word
  typedef struct packed {
    logic [15:0] x;
    logic [15:0] y;
  } gfx_point_t;

  // register word seen either raw or as a point
  typedef union packed {
    logic [31:0] raw;
    gfx_point_t  pt;
  } gfx_word_u;

  // one queued register write
  typedef struct packed {
    logic [GFX_REG_AW-1:0] adr;
    logic [31:0]           data;
  } gfx_cmd_t;

  // everything the fill stage needs for one rectangle
  // target_size.x is the width, target_size.y the height
  typedef struct packed {
    gfx_point_t  dest_p0;
    gfx_point_t  dest_p1;
    gfx_point_t  clip_p0;
    gfx_point_t  clip_p1;
    logic [29:0] target_base;
    gfx_point_t  target_size;
    logic [31:0] color;
  } gfx_rect_cmd_t;

  // one pixel write to video memory, word address
  typedef struct packed {
    logic [29:0] adr;
    logic [31:0] data;
  } gfx_mem_wr_t;

endpackage

// File: verilog/gfx_rect_raster.sv
// rectangle fill; needs cmd_i held stable until done_o, one multiply per fill, 32 bpp word writes
`timescale 1ns/10ps
module gfx_rect_raster (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   start_i,
  input  gfx_pkg::gfx_rect_cmd_t cmd_i,
  output logic                   done_o,
  output logic                   mem_valid_o,
  input  logic                   mem_ready_i,
  output gfx_pkg::gfx_mem_wr_t   mem_wr_o
);
  import gfx_pkg::*;

  typedef enum logic [1:0] {
    RS_IDLE,
    RS_SETUP,
    RS_RUN,
    RS_DONE
  } ras_state_t;

  ras_state_t state_q;

  // clipped bounds, hi edges exclusive
  logic [15:0] x_lo_q;
  logic [15:0] x_hi_q;
  logic [15:0] y_lo_q;
  logic [15:0] y_hi_q;

  // walk position and address of the current row start
  logic [15:0] x_q;
  logic [15:0] y_q;
  logic [29:0] row_adr_q;

  logic        empty;
  logic        last_col;
  logic        last_row;
  logic        mem_fire;
  logic [29:0] row_ofs;
  logic [29:0] width_w;

  function automatic logic [15:0] max2(input logic [15:0] a, input logic [15:0] b);
    return (a > b) ? a : b;
  endfunction

  function automatic logic [15:0] min3(input logic [15:0] a, input logic [15:0] b,
                                       input logic [15:0] c);
    logic [15:0] m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  // lower edges against zero need no compare, coordinates are unsigned
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      x_lo_q <= max2(cmd_i.dest_p0.x, cmd_i.clip_p0.x);
      y_lo_q <= max2(cmd_i.dest_p0.y, cmd_i.clip_p0.y);
      x_hi_q <= min3(cmd_i.dest_p1.x, cmd_i.clip_p1.x, cmd_i.target_size.x);
      y_hi_q <= min3(cmd_i.dest_p1.y, cmd_i.clip_p1.y, cmd_i.target_size.y);
    end
  end

  assign width_w = {14'd0, cmd_i.target_size.x};
  // only multiply, used once in the setup cycle
  assign row_ofs = y_lo_q * width_w;
  assign empty   = (x_lo_q >= x_hi_q) | (y_lo_q >= y_hi_q);

  assign last_col = (x_q + 16'd1 == x_hi_q);
  assign last_row = (y_q + 16'd1 == y_hi_q);

  assign mem_valid_o   = (state_q == RS_RUN);
  assign mem_fire      = mem_valid_o & mem_ready_i;
  assign mem_wr_o.adr  = row_adr_q + {14'd0, x_q};
  assign mem_wr_o.data = cmd_i.color;
  assign done_o        = (state_q == RS_DONE);

  // counters move only on accepted pixels, so the write holds under stall
  always_ff @(posedge clk_i)
  begin
    if (state_q == RS_SETUP)
    begin
      x_q       <= x_lo_q;
      y_q       <= y_lo_q;
      row_adr_q <= cmd_i.target_base + row_ofs;
    end
    else if (mem_fire)
    begin
      if (last_col)
      begin
        // wrap to next row
        x_q       <= x_lo_q;
        y_q       <= y_q + 16'd1;
        row_adr_q <= row_adr_q + width_w;
      end
      else
        x_q <= x_q + 16'd1;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      state_q <= RS_IDLE;
    else
    begin
      case (state_q)
        RS_IDLE:
          if (start_i)
            state_q <= RS_SETUP;
        RS_SETUP:
          // empty area still reports done, two cycles after start
          state_q <= empty ? RS_DONE : RS_RUN;
        RS_RUN:
          if (mem_fire && last_col && last_row)
            state_q <= RS_DONE;
        default:
          state_q <= RS_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/gfx_top.sv
// accelerator top; wishbone host port in, valid/ready video memory write port out, no memory reads
`timescale 1ns/10ps
module gfx_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [9:0]           adr_i,
  input  logic [31:0]          dat_i,
  output logic [31:0]          dat_o,
  input  logic [3:0]           sel_i,
  input  logic                 we_i,
  input  logic                 stb_i,
  input  logic                 cyc_i,
  output logic                 ack_o,
  output logic                 err_o,
  output logic                 inta_o,
  output logic                 mem_valid_o,
  input  logic                 mem_ready_i,
  output gfx_pkg::gfx_mem_wr_t mem_wr_o
);
  import gfx_pkg::*;

  // queue links
  logic     push_valid;
  logic     push_ready;
  gfx_cmd_t push_data;
  logic     pop_valid;
  logic     pop_ready;
  gfx_cmd_t pop_data;

  // slave to fill stage
  logic          rect_start;
  logic          rect_done;
  gfx_rect_cmd_t rect_cmd;

  gfx_wbs gfx_wbs_inst (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .adr_i             (adr_i),
    .dat_i             (dat_i),
    .dat_o             (dat_o),
    .sel_i             (sel_i),
    .we_i              (we_i),
    .stb_i             (stb_i),
    .cyc_i             (cyc_i),
    .ack_o             (ack_o),
    .err_o             (err_o),
    .inta_o            (inta_o),
    .rect_start_o      (rect_start),
    .rect_cmd_o        (rect_cmd),
    .rect_done_i       (rect_done),
    .fifo_push_valid_o (push_valid),
    .fifo_push_ready_i (push_ready),
    .fifo_push_data_o  (push_data),
    .fifo_pop_valid_i  (pop_valid),
    .fifo_pop_ready_o  (pop_ready),
    .fifo_pop_data_i   (pop_data)
  );

  gfx_cmd_fifo gfx_cmd_fifo_inst (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_valid_i (push_valid),
    .push_ready_o (push_ready),
    .push_data_i  (push_data),
    .pop_valid_o  (pop_valid),
    .pop_ready_i  (pop_ready),
    .pop_data_o   (pop_data)
  );

  gfx_rect_raster gfx_rect_raster_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .start_i     (rect_start),
    .cmd_i       (rect_cmd),
    .done_o      (rect_done),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_wr_o    (mem_wr_o)
  );

endmodule

// File: verilog/gfx_wbs.sv
// wishbone classic slave, 32-bit accesses only; reads do not see writes still queued, adr_i[9:8] ignored
`timescale 1ns/10ps
module gfx_wbs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [9:0]             adr_i,
  input  logic [31:0]            dat_i,
  output logic [31:0]            dat_o,
  input  logic [3:0]             sel_i,
  input  logic                   we_i,
  input  logic                   stb_i,
  input  logic                   cyc_i,
  output logic                   ack_o,
  output logic                   err_o,
  output logic                   inta_o,
  output logic                   rect_start_o,
  output gfx_pkg::gfx_rect_cmd_t rect_cmd_o,
  input  logic                   rect_done_i,
  output logic                   fifo_push_valid_o,
  input  logic                   fifo_push_ready_i,
  output gfx_pkg::gfx_cmd_t      fifo_push_data_o,
  input  logic                   fifo_pop_valid_i,
  output logic                   fifo_pop_ready_o,
  input  gfx_pkg::gfx_cmd_t      fifo_pop_data_i
);
  import gfx_pkg::*;

  // bus decode
  logic                  acc;
  logic                  acc32;
  logic                  reg_acc;
  logic [GFX_REG_AW-1:0] reg_idx;
  logic [31:0]           reg_dato;
  logic [31:0]           status_word;

  // register file
  logic [31:0] control_reg;
  logic [31:0] color_reg;
  logic [31:0] target_base_reg;
  gfx_word_u   dest_p0_reg;
  gfx_word_u   dest_p1_reg;
  gfx_word_u   clip_p0_reg;
  gfx_word_u   clip_p1_reg;
  gfx_word_u   target_size_reg;

  // busy state and sticky done
  logic busy_q;
  logic done_flag_q;
  logic launch_pending;
  logic pop_fire;

  assign acc     = cyc_i & stb_i;
  assign acc32   = (sel_i == 4'b1111);
  assign reg_acc = acc & acc32;
  assign reg_idx = adr_i[GFX_REG_AW+1:2];

  // writes go to the queue, never straight to the registers
  // blocked while ack is high so one access pushes once
  assign fifo_push_valid_o     = reg_acc & we_i & ~ack_o;
  assign fifo_push_data_o.adr  = reg_idx;
  assign fifo_push_data_o.data = dat_i;

  // ack one cycle after the access; a write only once the queue took it
  // full queue holds ack off, which stalls the host
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      ack_o <= 1'b0;
    else
      ack_o <= (reg_acc & ~we_i & ~ack_o) | (fifo_push_valid_o & fifo_push_ready_i);
  end

  // partial select is an error, nothing written
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      err_o <= 1'b0;
    else
      err_o <= acc & ~acc32 & ~err_o;
  end

  // registered read data
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      dat_o <= '0;
    else if (reg_acc && !we_i)
      dat_o <= reg_dato;
  end

  always_comb
  begin
    status_word                    = '0;
    status_word[GFX_STAT_BUSY_BIT] = busy_q;
    status_word[GFX_STAT_DONE_BIT] = done_flag_q;
  end

  always_comb
  begin
    case (reg_idx)
      GFX_CONTROL_ADR:     reg_dato = control_reg;
      GFX_STATUS_ADR:      reg_dato = status_word;
      GFX_DEST_P0_ADR:     reg_dato = dest_p0_reg.raw;
      GFX_DEST_P1_ADR:     reg_dato = dest_p1_reg.raw;
      GFX_CLIP_P0_ADR:     reg_dato = clip_p0_reg.raw;
      GFX_CLIP_P1_ADR:     reg_dato = clip_p1_reg.raw;
      GFX_COLOR_ADR:       reg_dato = color_reg;
      GFX_TARGET_BASE_ADR: reg_dato = target_base_reg;
      GFX_TARGET_SIZE_ADR: reg_dato = target_size_reg.raw;
      default:             reg_dato = '0;
    endcase
  end

  // rect bit set means a start is about to go out
  assign launch_pending   = control_reg[GFX_CTRL_RECT_BIT];
  // queue drains only while idle with nothing to launch
  assign fifo_pop_ready_o = ~busy_q & ~launch_pending;
  assign pop_fire         = fifo_pop_valid_i & fifo_pop_ready_o;
  assign rect_start_o     = ~busy_q & launch_pending;

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      control_reg     <= '0;
      color_reg       <= '0;
      target_base_reg <= '0;
      dest_p0_reg     <= '0;
      dest_p1_reg     <= '0;
      clip_p0_reg     <= '0;
      clip_p1_reg     <= '0;
      target_size_reg <= '0;
    end
    else if (pop_fire)
    begin
      case (fifo_pop_data_i.adr)
        GFX_CONTROL_ADR:     control_reg         <= fifo_pop_data_i.data;
        GFX_DEST_P0_ADR:     dest_p0_reg.raw     <= fifo_pop_data_i.data;
        GFX_DEST_P1_ADR:     dest_p1_reg.raw     <= fifo_pop_data_i.data;
        GFX_CLIP_P0_ADR:     clip_p0_reg.raw     <= fifo_pop_data_i.data;
        GFX_CLIP_P1_ADR:     clip_p1_reg.raw     <= fifo_pop_data_i.data;
        GFX_COLOR_ADR:       color_reg           <= fifo_pop_data_i.data;
        GFX_TARGET_BASE_ADR: target_base_reg     <= fifo_pop_data_i.data;
        GFX_TARGET_SIZE_ADR: target_size_reg.raw <= fifo_pop_data_i.data;
        default: ;
      endcase
    end
    else
      // self-clear in the start cycle, no pop can happen then
      control_reg[GFX_CTRL_RECT_BIT] <= 1'b0;
  end

  // idle/busy FSM, one bit is enough
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      busy_q <= 1'b0;
    else if (rect_start_o)
      busy_q <= 1'b1;
    else if (rect_done_i)
      busy_q <= 1'b0;
  end

  // sticky done, cleared by any queued write to status
  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      done_flag_q <= 1'b0;
    else if (rect_done_i)
      done_flag_q <= 1'b1;
    else if (pop_fire && fifo_pop_data_i.adr == GFX_STATUS_ADR)
      done_flag_q <= 1'b0;
  end

  assign inta_o = done_flag_q & control_reg[GFX_CTRL_INTEN_BIT];

  // registers only change while idle, so the command is stable during a fill
  assign rect_cmd_o.dest_p0     = dest_p0_reg.pt;
  assign rect_cmd_o.dest_p1     = dest_p1_reg.pt;
  assign rect_cmd_o.clip_p0     = clip_p0_reg.pt;
  assign rect_cmd_o.clip_p1     = clip_p1_reg.pt;
  // base register holds a word address, upper bits dropped
  assign rect_cmd_o.target_base = target_base_reg[29:0];
  assign rect_cmd_o.target_size = target_size_reg.pt;
  assign rect_cmd_o.color       = color_reg;

endmodule
